//--- include/cmd_encode_config.svh
/*
  widths, depths and opcodes for the dma write to tlx command encoder
  a line is always 128 bytes, handled as two 64-byte halves
  CE_FIFO_HIGH must leave room in the fifo for writes already in flight
*/
`ifndef CMD_ENCODE_CONFIG_SVH
`define CMD_ENCODE_CONFIG_SVH

// ====================
// geometry
`define CE_TAGW         7       // dma tag width
`define CE_LINE_BYTES   128     // one dma line
`define CE_HALF_BYTES   64      // one tlx 64B slot
`define CE_EA_W         64      // effective address

// ====================
// partial fifo
`define CE_FIFO_AW      5       // depth 32
`define CE_FIFO_HIGH    16      // intake stops at this count

// ====================
// tlx encodings
`define CE_OP_DMA_W     8'h20   // full write
`define CE_OP_DMA_PR_W  8'h30   // partial write
`define CE_DL_128       2'd2
`define CE_DL_64        2'd1

`endif

//--- source/cmd_encode_pkg.sv
/*
  packed types shared by the encoder rtl and its testbench
  field widths follow cmd_encode_config.svh
  prt_info_t is 194 bits with the default 7-bit tag
*/
`include "cmd_encode_config.svh"

package cmd_encode_pkg;

   typedef logic [`CE_LINE_BYTES*8-1:0] line_data_t;   // 1024 bits
   typedef logic [`CE_LINE_BYTES-1:0]   line_be_t;     // one bit per byte

   // command from the dma engine
   typedef struct packed {
      line_data_t           data;
      line_be_t             be;
      logic [`CE_EA_W-1:0]  ea;
      logic [`CE_TAGW-1:0]  tag;
   } dma_cmd_t;

   // one partial fifo entry
   typedef struct packed {
      logic                 prt_hi;      // upper half is partial
      logic                 prt_lo;      // lower half is partial
      logic [`CE_TAGW-1:0]  tag;
      logic [`CE_EA_W-8:0]  line_addr;   // ea[63:7]
      line_be_t             be;
   } prt_info_t;

   // command to tlx
   typedef struct packed {
      logic [7:0]           opcode;
      logic [`CE_EA_W-1:0]  ea;
      logic [15:0]          afutag;
      logic [1:0]           dl;
      logic [2:0]           pl;         // partial length, 2**pl bytes
      line_data_t           data;
   } tlx_cmd_t;

   // one aligned run out of the splitter
   typedef struct packed {
      logic [2:0]           pl;
      logic [5:0]           offset;     // byte offset inside the half
      logic [4:0]           cnt;        // piece index within the half
      logic                 last;
   } prt_piece_t;

endpackage

//--- source/dma_cmd_intake.sv
/*
  classifies both halves of an incoming dma line as full, empty or partial
  dma_cmd_valid_i is a one-cycle strobe, only legal while ready is high
  partial lines reach the fifo one register later
*/
`timescale 1ns/10ps
`include "cmd_encode_config.svh"

module dma_cmd_intake (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       dma_cmd_valid_i,
   input  cmd_encode_pkg::dma_cmd_t   dma_cmd_i,
   input  logic                       tlx_cmd_rdy_i,
   input  logic                       ctrl_idle_i,
   input  logic                       fifo_high_i,
   output logic                       dma_cmd_ready_o,
   output logic                       bypass_hi_o,
   output logic                       bypass_lo_o,
   output logic                       fifo_wr_o,
   output cmd_encode_pkg::prt_info_t  prt_info_o,
   output cmd_encode_pkg::line_data_t prt_data_o
);

   localparam int HB = `CE_HALF_BYTES;

   logic accept;
   logic full_hi, full_lo;
   logic prt_hi, prt_lo;

   // credit, no partial work in progress, fifo below high mark
   assign dma_cmd_ready_o = tlx_cmd_rdy_i & ctrl_idle_i & ~fifo_high_i;
   assign accept          = dma_cmd_valid_i & dma_cmd_ready_o;

   assign full_hi = &dma_cmd_i.be[2*HB-1:HB];
   assign full_lo = &dma_cmd_i.be[HB-1:0];
   assign prt_hi  = ~full_hi & (|dma_cmd_i.be[2*HB-1:HB]);   // some but not all
   assign prt_lo  = ~full_lo & (|dma_cmd_i.be[HB-1:0]);

   assign bypass_hi_o = accept & full_hi;   // straight to the mux
   assign bypass_lo_o = accept & full_lo;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         fifo_wr_o <= 1'b0;
      else
         fifo_wr_o <= accept & (prt_hi | prt_lo);
   end

   // fifo entry, both flags kept so the sequencer knows the second half
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         prt_info_o.prt_hi    <= prt_hi;
         prt_info_o.prt_lo    <= prt_lo;
         prt_info_o.tag       <= dma_cmd_i.tag;
         prt_info_o.line_addr <= dma_cmd_i.ea[`CE_EA_W-1:7];
         prt_info_o.be        <= dma_cmd_i.be;
         prt_data_o           <= dma_cmd_i.data;
      end
   end

endmodule

//--- source/partial_fifo.sv
/*
  synchronous fifo, depth 2**CE_FIFO_AW, payload chosen by type parameter
  dout_o is registered and valid one cycle after rd_i (rd_valid_o)
  a write into a full fifo is dropped, reads of an empty fifo are ignored
*/
`timescale 1ns/10ps
`include "cmd_encode_config.svh"

module partial_fifo #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     wr_i,
   input  payload_t din_i,
   input  logic     rd_i,
   output payload_t dout_o,
   output logic     empty_o,
   output logic     high_o,
   output logic     rd_valid_o
);

   localparam int AW    = `CE_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   payload_t        mem [DEPTH];
   logic [AW-1:0]   wr_ptr, rd_ptr;
   logic [AW:0]     count;          // one extra bit so full is representable
   logic            do_wr, do_rd;

   assign empty_o = (count == '0);
   assign high_o  = (count >= (AW+1)'(`CE_FIFO_HIGH));
   assign do_wr   = wr_i & ~count[AW];   // msb set only when full
   assign do_rd   = rd_i & ~empty_o;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         rd_valid_o <= 1'b0;
      end
      else
      begin
         rd_valid_o <= do_rd;
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;       // both or neither
         endcase
      end
   end

   // storage and read register
   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= din_i;
      if (do_rd)
         dout_o <= mem[rd_ptr];
   end

endmodule

//--- source/partial_slot_ctrl.sv
/*
  pulls partial entries from the fifo pair and feeds one 64-byte strobe
  at a time to the splitter, lower half first when both are partial
  the next entry is only read after the last piece of the current one
*/
`timescale 1ns/10ps
`include "cmd_encode_config.svh"

module partial_slot_ctrl (
   input  logic                           clk,
   input  logic                           rst_n,
   input  cmd_encode_pkg::prt_info_t      info_i,
   input  cmd_encode_pkg::line_data_t     data_i,
   input  logic                           info_empty_i,
   input  logic                           info_valid_i,
   input  cmd_encode_pkg::prt_piece_t     piece_i,
   input  logic                           piece_valid_i,
   output logic                           rd_o,
   output logic                           idle_o,
   output logic [`CE_HALF_BYTES-1:0]      strobe_o,
   output logic                           strobe_valid_o,
   output logic [`CE_HALF_BYTES*8-1:0]    half_data_o,
   output logic [`CE_EA_W-8:0]            line_addr_o,
   output logic [`CE_TAGW-1:0]            tag_o,
   output logic                           sel_hi_o
);

   localparam int HB = `CE_HALF_BYTES;
   localparam int HW = HB*8;

   typedef enum logic [2:0] {IDLE, RD_FIFO, CHECK, LOW_HALF, HIGH_HALF} state_t;

   state_t          state_q, state_d;
   logic            second_q;       // upper half still to do after the lower
   logic            done;           // last piece of the current half
   logic            load;           // entry on the fifo output is taken
   logic            to_hi;          // lower half finished, upper follows
   logic [HB-1:0]   hi_be_q;        // saved upper strobe
   logic [HW-1:0]   hi_data_q;      // saved upper data

   assign done     = piece_valid_i & piece_i.last;
   assign load     = (state_q == CHECK) & info_valid_i;
   assign to_hi    = (state_q == LOW_HALF) & done & second_q;
   assign rd_o     = (state_q == RD_FIFO);
   assign idle_o   = (state_q == IDLE);
   assign sel_hi_o = (state_q == HIGH_HALF);

   // ====================
   // state machine
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:      if (!info_empty_i) state_d = RD_FIFO;
         RD_FIFO:   state_d = CHECK;            // dout valid next cycle
         CHECK:     if (info_valid_i) state_d = info_i.prt_lo ? LOW_HALF : HIGH_HALF;
         LOW_HALF:  if (done) state_d = second_q ? HIGH_HALF : IDLE;
         HIGH_HALF: if (done) state_d = IDLE;
         default:   state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q        <= IDLE;
         second_q       <= 1'b0;
         strobe_valid_o <= 1'b0;
      end
      else
      begin
         state_q        <= state_d;
         strobe_valid_o <= load | to_hi;      // single pulse per half
         if (load)
            second_q <= info_i.prt_lo & info_i.prt_hi;
      end
   end

   // ====================
   // half select and saved upper half
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         tag_o       <= info_i.tag;
         line_addr_o <= info_i.line_addr;
         hi_be_q     <= info_i.be[2*HB-1:HB];
         hi_data_q   <= data_i[2*HW-1:HW];
         if (info_i.prt_lo)
         begin
            strobe_o    <= info_i.be[HB-1:0];
            half_data_o <= data_i[HW-1:0];
         end
         else
         begin
            strobe_o    <= info_i.be[2*HB-1:HB];
            half_data_o <= data_i[2*HW-1:HW];
         end
      end
      else if (to_hi)
      begin
         strobe_o    <= hi_be_q;
         half_data_o <= hi_data_q;   // lower half already sent
      end
   end

endmodule

//--- source/byte_run_splitter.sv
/*
  splits a 64-bit byte strobe into naturally aligned power-of-two runs
  up to 32 bytes each, one piece per cycle while enable_i is high
  the strobe is loaded on the pulse, pieces start the cycle after
*/
`timescale 1ns/10ps
`include "cmd_encode_config.svh"

module byte_run_splitter (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        enable_i,
   input  logic [`CE_HALF_BYTES-1:0]   strobe_i,
   input  logic                        strobe_valid_i,
   output cmd_encode_pkg::prt_piece_t  piece_o,
   output logic                        piece_valid_o
);

   localparam int HB = `CE_HALF_BYTES;

   logic [HB-1:0] rem_q;       // bytes not yet sent
   logic [HB-1:0] run;         // rem_q shifted down to p
   logic [HB-1:0] len_mask;
   logic [HB-1:0] clr_mask;    // bytes covered by this piece
   logic [4:0]    cnt_q;
   logic          active_q;
   logic [5:0]    p;           // lowest remaining byte

   assign piece_valid_o = active_q & enable_i;   // held during back-pressure

   always_comb
   begin
      p = '0;
      for (int i = HB-1; i >= 0; i--)
         if (rem_q[i]) p = 6'(i);
      run = rem_q >> p;
      piece_o.pl = '0;
      // alignment and run length only get stricter with k, keep the last fit
      for (int k = 1; k <= 5; k++)
      begin
         len_mask = (HB'(1) << (1 << k)) - HB'(1);
         if ((p & ((6'd1 << k) - 6'd1)) == 6'd0 && (run & len_mask) == len_mask)
            piece_o.pl = 3'(k);
      end
      clr_mask       = ((HB'(1) << (1 << piece_o.pl)) - HB'(1)) << p;
      piece_o.offset = p;
      piece_o.cnt    = cnt_q;
      piece_o.last   = ((rem_q & ~clr_mask) == '0);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active_q <= 1'b0;
         cnt_q    <= '0;
      end
      else if (strobe_valid_i)
      begin
         active_q <= 1'b1;
         cnt_q    <= '0;
      end
      else if (piece_valid_o)
      begin
         active_q <= ~piece_o.last;
         cnt_q    <= cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (strobe_valid_i)
         rem_q <= strobe_i;
      else if (piece_valid_o)
         rem_q <= rem_q & ~clr_mask;
   end

endmodule

//--- source/tlx_cmd_mux.sv
/*
  builds the tlx command from the bypass path or the partial path
  bypass wins, the splitter is held off in bypass cycles
  one register from selection to tlx_cmd_valid_o
*/
`timescale 1ns/10ps
`include "cmd_encode_config.svh"

module tlx_cmd_mux (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          bypass_hi_i,
   input  logic                          bypass_lo_i,
   input  cmd_encode_pkg::dma_cmd_t      dma_cmd_i,
   input  cmd_encode_pkg::prt_piece_t    piece_i,
   input  logic                          piece_valid_i,
   input  logic [`CE_HALF_BYTES*8-1:0]   half_data_i,
   input  logic [`CE_EA_W-8:0]           line_addr_i,
   input  logic [`CE_TAGW-1:0]           tag_i,
   input  logic                          sel_hi_i,
   output logic                          tlx_cmd_valid_o,
   output cmd_encode_pkg::tlx_cmd_t      tlx_cmd_o
);

   localparam int HW = `CE_HALF_BYTES*8;

   cmd_encode_pkg::tlx_cmd_t cmd_d;
   logic                     bypass;

   assign bypass = bypass_hi_i | bypass_lo_i;

   // afutag: [14] partial, [13:9] cnt, [8:7] half select, low bits tag
   always_comb
   begin
      cmd_d = '0;
      if (bypass)
      begin
         cmd_d.opcode = `CE_OP_DMA_W;
         cmd_d.afutag = 16'({bypass_hi_i, bypass_lo_i, dma_cmd_i.tag});
         cmd_d.data   = dma_cmd_i.data;
         if (bypass_hi_i && bypass_lo_i)
         begin
            cmd_d.ea = dma_cmd_i.ea;   // whole 128B line
            cmd_d.dl = `CE_DL_128;
         end
         else
         begin
            cmd_d.ea = {dma_cmd_i.ea[`CE_EA_W-1:7], bypass_hi_i, 6'd0};
            cmd_d.dl = `CE_DL_64;
            if (bypass_hi_i)
               cmd_d.data = {dma_cmd_i.data[HW-1:0], dma_cmd_i.data[2*HW-1:HW]};   // valid 64B low
         end
      end
      else
      begin
         cmd_d.opcode = `CE_OP_DMA_PR_W;
         cmd_d.afutag = 16'({2'b01, piece_i.cnt, sel_hi_i, ~sel_hi_i, tag_i});
         cmd_d.ea     = {line_addr_i, sel_hi_i, piece_i.offset};
         cmd_d.dl     = `CE_DL_64;
         cmd_d.pl     = piece_i.pl;
         cmd_d.data   = {{HW{1'b0}}, half_data_i};
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         tlx_cmd_valid_o <= 1'b0;
      else
         tlx_cmd_valid_o <= bypass | piece_valid_i;
   end

   always_ff @(posedge clk)
   begin
      if (bypass || piece_valid_i)
         tlx_cmd_o <= cmd_d;
   end

endmodule

//--- source/cmd_encode_top.sv
/*
  dma write command encoder, 128B dma lines in, tlx write commands out
  full halves bypass in one cycle, partial halves queue for the splitter
  tlx_cmd_rdy_i low stops intake and holds the splitter in place
*/
`timescale 1ns/10ps
`include "cmd_encode_config.svh"

module cmd_encode_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      dma_cmd_valid_i,
   input  cmd_encode_pkg::dma_cmd_t  dma_cmd_i,
   output logic                      dma_cmd_ready_o,
   input  logic                      tlx_cmd_rdy_i,
   output logic                      tlx_cmd_valid_o,
   output cmd_encode_pkg::tlx_cmd_t  tlx_cmd_o
);

   cmd_encode_pkg::prt_info_t   fifo_info_din, fifo_info_dout;
   cmd_encode_pkg::line_data_t  fifo_data_din, fifo_data_dout;
   cmd_encode_pkg::prt_piece_t  piece;
   logic                        fifo_wr, fifo_rd;
   logic                        info_empty, info_high, info_valid;
   logic                        bypass_hi, bypass_lo;
   logic                        ctrl_idle;
   logic [`CE_HALF_BYTES-1:0]   strobe;
   logic                        strobe_valid;
   logic                        piece_valid;
   logic [`CE_HALF_BYTES*8-1:0] half_data;
   logic [`CE_EA_W-8:0]         line_addr;
   logic [`CE_TAGW-1:0]         tag;
   logic                        sel_hi;

   // splitter pauses on missing credit and on bypass cycles
   wire split_en = tlx_cmd_rdy_i & ~(bypass_hi | bypass_lo);

   // ====================
   // intake
   dma_cmd_intake u_intake (
      .clk (clk), .rst_n (rst_n),
      .dma_cmd_valid_i (dma_cmd_valid_i), .dma_cmd_i (dma_cmd_i),
      .tlx_cmd_rdy_i (tlx_cmd_rdy_i), .ctrl_idle_i (ctrl_idle),
      .fifo_high_i (info_high), .dma_cmd_ready_o (dma_cmd_ready_o),
      .bypass_hi_o (bypass_hi), .bypass_lo_o (bypass_lo),
      .fifo_wr_o (fifo_wr), .prt_info_o (fifo_info_din), .prt_data_o (fifo_data_din)
   );

   // ====================
   // partial path, info and data fifos move in lock step
   partial_fifo #(.payload_t (cmd_encode_pkg::prt_info_t)) u_info_fifo (
      .clk (clk), .rst_n (rst_n), .wr_i (fifo_wr), .din_i (fifo_info_din),
      .rd_i (fifo_rd), .dout_o (fifo_info_dout), .empty_o (info_empty),
      .high_o (info_high), .rd_valid_o (info_valid)
   );

   partial_fifo #(.payload_t (cmd_encode_pkg::line_data_t)) u_data_fifo (
      .clk (clk), .rst_n (rst_n), .wr_i (fifo_wr), .din_i (fifo_data_din),
      .rd_i (fifo_rd), .dout_o (fifo_data_dout), .empty_o (),
      .high_o (), .rd_valid_o ()
   );

   partial_slot_ctrl u_slot_ctrl (
      .clk (clk), .rst_n (rst_n), .info_i (fifo_info_dout), .data_i (fifo_data_dout),
      .info_empty_i (info_empty), .info_valid_i (info_valid),
      .piece_i (piece), .piece_valid_i (piece_valid), .rd_o (fifo_rd),
      .idle_o (ctrl_idle), .strobe_o (strobe), .strobe_valid_o (strobe_valid),
      .half_data_o (half_data), .line_addr_o (line_addr), .tag_o (tag), .sel_hi_o (sel_hi)
   );

   byte_run_splitter u_splitter (
      .clk (clk), .rst_n (rst_n), .enable_i (split_en),
      .strobe_i (strobe), .strobe_valid_i (strobe_valid),
      .piece_o (piece), .piece_valid_o (piece_valid)
   );

   // ====================
   // output
   tlx_cmd_mux u_mux (
      .clk (clk), .rst_n (rst_n), .bypass_hi_i (bypass_hi), .bypass_lo_i (bypass_lo),
      .dma_cmd_i (dma_cmd_i), .piece_i (piece), .piece_valid_i (piece_valid),
      .half_data_i (half_data), .line_addr_i (line_addr), .tag_i (tag),
      .sel_hi_i (sel_hi), .tlx_cmd_valid_o (tlx_cmd_valid_o), .tlx_cmd_o (tlx_cmd_o)
   );

endmodule

//--- sim/tb_clk_gen.sv
/*
  20 ns clock, active low reset held for the first 8 rising edges
*/
`timescale 1ns/10ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;   // 20 ns period
   end

   initial
   begin
      rst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      #1 rst_n_o = 1'b1;            // release just off the edge
   end

endmodule

//--- sim/cmd_encode_assertions.sv
/*
  internal protocol checks, bound into cmd_encode_top
  sampled on the rising clock, quiet while rst_n is low
*/
`timescale 1ns/10ps

module cmd_encode_assertions (
   input logic clk,
   input logic rst_n,
   input logic strobe_valid_i,
   input logic piece_valid_i,
   input logic bypass_hi_i,
   input logic bypass_lo_i,
   input logic tlx_cmd_rdy_i,
   input logic dma_cmd_ready_i
);

   // splitter load, one pulse per half
   strobe_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      strobe_valid_i |=> !strobe_valid_i)
      else $error("strobe_valid high for more than one cycle");

   // bypass owns the mux in its cycle
   bypass_excl: assert property (@(posedge clk) disable iff (!rst_n)
      (bypass_hi_i || bypass_lo_i) |-> !piece_valid_i)
      else $error("piece valid in a bypass cycle");

   // no tlx credit, no intake
   credit_stop: assert property (@(posedge clk) disable iff (!rst_n)
      !tlx_cmd_rdy_i |-> !dma_cmd_ready_i)
      else $error("dma_cmd_ready_o high without tlx credit");

endmodule

bind cmd_encode_top cmd_encode_assertions u_assertions (
   .clk (clk), .rst_n (rst_n), .strobe_valid_i (strobe_valid),
   .piece_valid_i (piece_valid), .bypass_hi_i (bypass_hi), .bypass_lo_i (bypass_lo),
   .tlx_cmd_rdy_i (tlx_cmd_rdy_i), .dma_cmd_ready_i (dma_cmd_ready_o)
);

//--- sim/tb_cmd_encode.sv
/*
  testbench for the dma write to tlx command encoder
  expected commands come from ref_encode and are matched by afutag,
  so tags must stay unique among the commands in flight (128 at most)
  inputs change 1 ns after the rising edge, outputs are read on the falling edge
*/
`timescale 1ns/10ps
`include "cmd_encode_config.svh"

module tb_cmd_encode;

   localparam int TIMEOUT = 2000;   // cycles for any single wait

   logic                      clk, rst_n;
   logic                      dma_cmd_valid_i;
   cmd_encode_pkg::dma_cmd_t  dma_cmd_i;
   logic                      dma_cmd_ready_o;
   logic                      tlx_cmd_rdy_i;
   logic                      tlx_cmd_valid_o;
   cmd_encode_pkg::tlx_cmd_t  tlx_cmd_o;

   cmd_encode_pkg::tlx_cmd_t  exp_q[$];     // commands the dut still owes
   int                        got_total;
   logic [31:0]               seed;
   logic [`CE_TAGW-1:0]       tag_ctr;

   tb_clk_gen u_clk (.clk_o (clk), .rst_n_o (rst_n));

   cmd_encode_top DUT (
      .clk (clk), .rst_n (rst_n),
      .dma_cmd_valid_i (dma_cmd_valid_i), .dma_cmd_i (dma_cmd_i),
      .dma_cmd_ready_o (dma_cmd_ready_o), .tlx_cmd_rdy_i (tlx_cmd_rdy_i),
      .tlx_cmd_valid_o (tlx_cmd_valid_o), .tlx_cmd_o (tlx_cmd_o)
   );

   // ====================
   // reporting and checks
   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic value_error(input string name, input logic [1023:0] e, input logic [1023:0] g);
      fail_now($sformatf("MISMATCH %s expected %h got %h", name, e, g));
   endtask

   task automatic check_cmd(input cmd_encode_pkg::tlx_cmd_t e, input cmd_encode_pkg::tlx_cmd_t g);
      if (g.opcode !== e.opcode)
         value_error("tlx_cmd_o.opcode", 1024'(e.opcode), 1024'(g.opcode));
      if (g.ea !== e.ea)
         value_error("tlx_cmd_o.ea", 1024'(e.ea), 1024'(g.ea));
      if (g.dl !== e.dl)
         value_error("tlx_cmd_o.dl", 1024'(e.dl), 1024'(g.dl));
      if (g.pl !== e.pl)
         value_error("tlx_cmd_o.pl", 1024'(e.pl), 1024'(g.pl));
      if (g.data !== e.data)
         value_error("tlx_cmd_o.data", e.data, g.data);
   endtask

   task automatic check_count(input int e, input int g);
      if (g != e)
         fail_now($sformatf("MISMATCH tlx_cmd_valid_o count expected %h got %h", e, g));
   endtask

   // ====================
   // random stimulus
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      seed = xorshift32(seed);
      return seed;
   endfunction

   // some but not all of the 64 bytes
   function automatic logic [63:0] rand_partial();
      logic [31:0] r;
      logic [63:0] b;
      r = next_rand();
      case (r[1:0])
         2'd0:    b = {next_rand(), next_rand()};                              // scattered
         2'd1:    b = {next_rand(), next_rand()} | {next_rand(), next_rand()}; // dense
         default: b = ((64'h1 << (7'(r[7:2]) + 7'd1)) - 64'h1) << r[13:8];     // one run
      endcase
      if (b == '0)
         b[r[19:14]] = 1'b1;
      if (&b)
         b[r[19:14]] = 1'b0;
      return b;
   endfunction

   // kind 0 empty, 1 full, 2 partial
   function automatic logic [63:0] make_half(input int kind);
      if (kind == 0)
         return '0;
      if (kind == 1)
         return '1;
      return rand_partial();
   endfunction

   function automatic cmd_encode_pkg::dma_cmd_t make_cmd(input int kind_hi, input int kind_lo);
      cmd_encode_pkg::dma_cmd_t c;
      for (int i = 0; i < 32; i++)
         c.data[i*32 +: 32] = next_rand();
      c.be      = {make_half(kind_hi), make_half(kind_lo)};
      c.ea      = {next_rand(), next_rand()};
      c.ea[6:0] = '0;                    // line aligned
      c.tag     = tag_ctr;
      tag_ctr   = tag_ctr + 1'b1;
      return c;
   endfunction

   // ====================
   // reference model
   function automatic logic block_set(input logic [63:0] v, input int p, input int n);
      if (p + n > 64)
         return 1'b0;
      for (int i = p; i < p + n; i++)
         if (!v[i])
            return 1'b0;
      return 1'b1;
   endfunction

   // aligned power-of-two runs of one half, lowest byte first
   function automatic void split_ref(input cmd_encode_pkg::dma_cmd_t c, input logic hi,
                                     input logic [63:0] be, input logic [511:0] d);
      cmd_encode_pkg::tlx_cmd_t t;
      logic [63:0]              rem;
      int                       p, k, cnt;
      rem = be;
      cnt = 0;
      while (rem != '0)
      begin
         p = 0;
         while (!rem[p])
            p++;
         k = 0;
         while (k < 5 && p % (2 << k) == 0 && block_set(rem, p, 2 << k))
            k++;                         // next size still aligned and enabled
         for (int i = p; i < p + (1 << k); i++)
            rem[i] = 1'b0;
         t        = '0;
         t.opcode = `CE_OP_DMA_PR_W;
         t.ea     = {c.ea[63:7], hi, 6'(p)};
         t.afutag = {2'b01, 5'(cnt), hi, ~hi, c.tag};
         t.dl     = `CE_DL_64;
         t.pl     = 3'(k);
         t.data   = {512'd0, d};         // half data in the low 64 bytes
         exp_q.push_back(t);
         cnt++;
      end
   endfunction

   function automatic void ref_encode(input cmd_encode_pkg::dma_cmd_t c);
      cmd_encode_pkg::tlx_cmd_t t;
      logic                     full_lo, full_hi;
      full_lo = &c.be[63:0];
      full_hi = &c.be[127:64];
      if (full_lo || full_hi)
      begin
         t        = '0;
         t.opcode = `CE_OP_DMA_W;
         t.afutag = {7'd0, full_hi, full_lo, c.tag};
         t.data   = c.data;
         t.ea     = {c.ea[63:7], full_hi, 6'd0};
         t.dl     = `CE_DL_64;
         if (full_lo && full_hi)
         begin
            t.ea = c.ea;
            t.dl = `CE_DL_128;
         end
         else if (full_hi)
            t.data = {c.data[511:0], c.data[1023:512]};   // upper half moves down
         exp_q.push_back(t);
      end
      if (!full_lo && c.be[63:0] != '0)
         split_ref(c, 1'b0, c.be[63:0], c.data[511:0]);
      if (!full_hi && c.be[127:64] != '0)
         split_ref(c, 1'b1, c.be[127:64], c.data[1023:512]);
   endfunction

   // ====================
   // compare process
   always @(negedge clk)
   begin : compare_out
      int idx;
      if (rst_n && tlx_cmd_valid_o)
      begin
         idx = -1;
         foreach (exp_q[i])
            if (exp_q[i].afutag == tlx_cmd_o.afutag)
               idx = i;
         if (idx < 0)
            fail_now($sformatf("unexpected tlx command with afutag %h", tlx_cmd_o.afutag));
         else
         begin
            check_cmd(exp_q[idx], tlx_cmd_o);
            exp_q.delete(idx);
            got_total++;
         end
      end
   end

   // ====================
   // drive helpers
   task automatic send_cmd(input cmd_encode_pkg::dma_cmd_t c);
      int t;
      t = 0;
      @(posedge clk);
      #1;
      while (!dma_cmd_ready_o && t < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         t++;
      end
      if (!dma_cmd_ready_o)
         fail_now("dma_cmd_ready_o stayed low, command could not be sent");
      ref_encode(c);
      dma_cmd_i       = c;
      dma_cmd_valid_i = 1'b1;           // one-cycle strobe
      @(posedge clk);
      #1;
      dma_cmd_valid_i = 1'b0;
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while ((exp_q.size() != 0 || !dma_cmd_ready_o) && t < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         t++;
      end
      if (exp_q.size() != 0)
         fail_now($sformatf("timeout, %0d expected tlx commands never came", exp_q.size()));
      if (!dma_cmd_ready_o)
         fail_now("timeout, encoder did not return to ready");
   endtask

   // credit withheld for n cycles, intake must stay closed
   task automatic stall(input int n);
      tlx_cmd_rdy_i = 1'b0;
      for (int i = 0; i < n; i++)
      begin
         @(posedge clk);
         #1;
         if (dma_cmd_ready_o)
            fail_now("dma_cmd_ready_o high while tlx_cmd_rdy_i is low");
      end
      tlx_cmd_rdy_i = 1'b1;
   endtask

   // ====================
   // stimulus
   initial
   begin : stimulus
      cmd_encode_pkg::dma_cmd_t c;
      logic [31:0]              r;
      int                       t, base;
      dma_cmd_valid_i = 1'b0;
      dma_cmd_i       = '0;
      tlx_cmd_rdy_i   = 1'b1;
      seed            = 32'h1186f0d5;
      tag_ctr         = '0;
      got_total       = 0;
      t               = 0;
      while (!rst_n && t < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         t++;
      end
      if (!rst_n)
         fail_now("reset was never released");

      // full line, then each single full half, out right after acceptance
      for (int i = 0; i < 3; i++)
      begin
         base = got_total;
         send_cmd(make_cmd((i == 2) ? 0 : 1, (i == 1) ? 0 : 1));
         if (!tlx_cmd_valid_o)
            fail_now("bypass command missing in the cycle after acceptance");
         wait_drain();
         check_count(1, got_total - base);   // exactly one write per full line or half
      end

      // partial low, partial high, both partial
      for (int i = 0; i < 24; i++)
      begin
         send_cmd(make_cmd((i % 3 == 0) ? 0 : 2, (i % 3 == 1) ? 0 : 2));
         wait_drain();
      end

      // one full and one partial half
      send_cmd(make_cmd(1, 2));
      wait_drain();
      send_cmd(make_cmd(2, 1));
      wait_drain();

      // credit withheld in the middle of a long split
      c          = make_cmd(2, 2);
      c.be[63:0] = 64'h5555_5555_5555_5555;   // 32 single bytes
      send_cmd(c);
      base = got_total;
      t    = 0;
      while (got_total == base && t < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         t++;
      end
      if (got_total == base)
         fail_now("no partial command came out");
      tlx_cmd_rdy_i = 1'b0;
      @(posedge clk);                  // command already registered still leaves
      #1;
      base = got_total;
      for (int i = 0; i < 12; i++)
      begin
         @(posedge clk);
         #1;
         if (dma_cmd_ready_o)
            fail_now("dma_cmd_ready_o high while tlx_cmd_rdy_i is low");
         check_count(base, got_total);
      end
      tlx_cmd_rdy_i = 1'b1;
      wait_drain();

      // random burst with short credit stalls
      for (int i = 0; i < 40; i++)
      begin
         r = next_rand();
         send_cmd(make_cmd(int'(r[1:0]) % 3, int'(r[3:2]) % 3));
         if (r[4])
            stall(int'(r[7:5]) + 1);
      end
      wait_drain();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- all.f
+incdir+include
source/cmd_encode_pkg.sv
source/dma_cmd_intake.sv
source/partial_fifo.sv
source/partial_slot_ctrl.sv
source/byte_run_splitter.sv
source/tlx_cmd_mux.sv
source/cmd_encode_top.sv
sim/tb_clk_gen.sv
sim/cmd_encode_assertions.sv
sim/tb_cmd_encode.sv

//--- run.sh
#!/bin/sh
# build and run the encoder testbench with verilator, exit status follows the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_cmd_encode \
   -o tb_sim || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation ended without a pass report"; exit 1; }
echo "simulation passed"
